// ==== compile.f ====
pwm_pkg.sv
bus_handshake_fsm.sv
pwm_timer_fsm.sv
pwm_channel.sv
pwm_subsystem.sv
tb_pwm_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the PWM subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_pwm_subsystem \
   -Mdir obj_dir -o sim_pwm > build.log 2>&1 \
   && ./obj_dir/sim_pwm > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log

# the log decides the result
grep -qF '*** FAILED ***' sim.log && { echo "simulation reported failure"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "no pass line in log"; exit 1; }
exit 0

// ==== tb_pwm_subsystem.sv ====
/*
 * testbench for the PWM subsystem
 *   host bus tasks, run-length monitor on every PWM output,
 *   handshake assertions, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_pwm_subsystem import pwm_pkg::*; ();

   localparam int NUM_CH        = 4;
   localparam int CLK_PERIOD    = 20;
   localparam int ACCESSES      = 130;
   localparam int ACCESS_CYCLES = 8 + 12;
   localparam int WAIT_LIMIT    = 300;
   localparam int WAITS         = 12;
   // bus accesses plus every bounded wait and a margin
   localparam int WATCHDOG_CYCLES = 16 + ACCESSES * ACCESS_CYCLES + WAITS * WAIT_LIMIT + 500;

   logic                  clk = 1'b0;
   logic                  reset, req, rw, ack;
   logic [ADDR_WIDTH-1:0] addr;
   logic [DATA_WIDTH-1:0] wdata, rdata;
   logic [NUM_CH-1:0]     pwm_out;

   integer seed = 63006;
   int errors = 0;
   int mon_errors = 0;
   int rise_errors = 0;
   int hold_errors = 0;
   int fall_errors = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int start_errors = 0;

   // run-length monitor state and expected run lengths
   logic last_level [NUM_CH] = '{default: 1'b0};
   int   run_len [NUM_CH]    = '{default: 0};
   int   n_runs [NUM_CH]     = '{default: 0};
   int   check_after [NUM_CH];
   int   exp_hi [NUM_CH];
   int   exp_lo [NUM_CH];
   int   per [NUM_CH];
   int   on_t [NUM_CH];

   always #(CLK_PERIOD/2) clk = ~clk;

   pwm_subsystem #(
      .NUM_CHANNELS (NUM_CH)
   ) UUT (
      .clk     (clk),
      .reset   (reset),
      .req     (req),
      .rw      (rw),
      .addr    (addr),
      .wdata   (wdata),
      .ack     (ack),
      .rdata   (rdata),
      .pwm_out (pwm_out)
   );

   a_ack_delay: assert property (@(posedge clk) disable iff (!reset)
      $rose(req) |-> ##1 !ack ##1 ack)
      else begin
         $display("ack did not rise two edges after req was sampled");
         rise_errors++;
      end

   a_ack_hold: assert property (@(posedge clk) disable iff (!reset)
      (req && ack) |=> ack)
      else begin
         $display("ack dropped while req was still held");
         hold_errors++;
      end

   a_ack_fall: assert property (@(posedge clk) disable iff (!reset)
      $fell(req) |-> ack ##1 !ack)
      else begin
         $display("ack did not fall one edge after req dropped");
         fall_errors++;
      end

   // a completed run is checked once the run in progress at arming is past
   always @(negedge clk) begin
      for (int i = 0; i < NUM_CH; i++) begin
         if (pwm_out[i] !== last_level[i]) begin
            n_runs[i]++;
            assert (n_runs[i] <= check_after[i] ||
                    run_len[i] == (last_level[i] ? exp_hi[i] : exp_lo[i])) else begin
               $display("MISMATCH pwm_out[%0d] %s run: got %h, expected %h", i,
                        last_level[i] ? "high" : "low", run_len[i],
                        last_level[i] ? exp_hi[i] : exp_lo[i]);
               mon_errors++;
            end
            last_level[i] = pwm_out[i];
            run_len[i]    = 1;
         end else begin
            run_len[i]++;
         end
      end
   end

   function automatic int total_errors();
      return errors + mon_errors + rise_errors + hold_errors + fall_errors;
   endfunction

   function automatic logic [ADDR_WIDTH-1:0] reg_addr(input int ch,
                                                       input logic [REG_SEL_WIDTH-1:0] r);
      return ADDR_WIDTH'(ch * REGS_PER_CHANNEL + int'(r));
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // one four-phase transfer with ack held for stall extra cycles
   task automatic bus_access(input logic write, input logic [ADDR_WIDTH-1:0] a,
                             input logic [DATA_WIDTH-1:0] d, input int stall,
                             output logic [DATA_WIDTH-1:0] q);
      int n;
      @(posedge clk);
      req   <= 1'b1;
      rw    <= write;
      addr  <= a;
      wdata <= d;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ack && n < 10);
      assert (ack) else begin
         $display("no ack for bus access to address %h", a);
         errors++;
      end
      check_value("ack latency", 32'(n), 3);
      q = rdata;
      repeat (stall) begin
         @(negedge clk);
         check_value("ack", 32'(ack), 1);
      end
      @(posedge clk);
      req <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (ack && n < 10);
      assert (!ack) else begin
         $display("ack stuck high after req dropped at address %h", a);
         errors++;
      end
   endtask

   task automatic bus_write(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d);
      logic [DATA_WIDTH-1:0] q;
      bus_access(1'b1, a, d, 0, q);
      check_value("rdata on write", q, 0);
   endtask

   task automatic bus_read(input logic [ADDR_WIDTH-1:0] a, output logic [DATA_WIDTH-1:0] q);
      bus_access(1'b0, a, '0, 0, q);
   endtask

   task automatic arm(input int ch, input int hi, input int lo);
      @(posedge clk);
      exp_hi[ch]      = hi;
      exp_lo[ch]      = lo;
      check_after[ch] = n_runs[ch] + 1;
   endtask

   task automatic wait_runs(input int ch, input int count);
      int start;
      int n;
      start = n_runs[ch];
      n = 0;
      while (n_runs[ch] < start + count && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert (n_runs[ch] >= start + count) else begin
         $display("pwm_out[%0d] stopped toggling", ch);
         errors++;
      end
   endtask

   task automatic wait_level(input int ch, input logic level);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (pwm_out[ch] !== level && n < WAIT_LIMIT);
      assert (pwm_out[ch] === level) else begin
         $display("pwm_out[%0d] never reached level %0d", ch, level);
         errors++;
      end
   endtask

   task automatic hold_level(input int ch, input logic level, input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_value($sformatf("pwm_out[%0d]", ch), 32'(pwm_out[ch]), 32'(level));
      end
   endtask

   task automatic test_done(input string name);
      if (total_errors() == start_errors) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, total_errors() - start_errors);
      end
      start_errors = total_errors();
   endtask

   initial begin
      logic [DATA_WIDTH-1:0] p, o, c, s, q;
      reset = 1'b0;
      req   = 1'b0;
      rw    = 1'b0;
      addr  = '0;
      wdata = '0;
      for (int i = 0; i < NUM_CH; i++) begin
         check_after[i] = 1 << 30;
         exp_hi[i]      = 0;
         exp_lo[i]      = 0;
      end
      repeat (16) @(posedge clk);
      reset <= 1'b1;

      @(negedge clk);
      check_value("ack", 32'(ack), 0);
      check_value("pwm_out", 32'(pwm_out), 0);
      for (int a = 0; a < NUM_CH * REGS_PER_CHANNEL; a++) begin
         bus_read(ADDR_WIDTH'(a), q);
         check_value($sformatf("rdata at %0d", a), q, 0);
      end
      test_done("reset state");

      for (int ch = 0; ch < NUM_CH; ch++) begin
         p = $random(seed);
         o = $random(seed);
         c = $random(seed);
         s = $random(seed);
         bus_write(reg_addr(ch, REG_PERIOD), p);
         bus_write(reg_addr(ch, REG_ON_TIME), o);
         bus_write(reg_addr(ch, REG_CONFIG), c);
         bus_write(reg_addr(ch, REG_STATUS), s);
         bus_read(reg_addr(ch, REG_PERIOD), q);
         check_value("period", q, p);
         bus_read(reg_addr(ch, REG_ON_TIME), q);
         check_value("on_time", q, o);
         bus_read(reg_addr(ch, REG_CONFIG), q);
         check_value("config", q, {31'b0, c[CFG_ENABLE_BIT]});
         // running and level depend on the timer so only enable is fixed
         bus_read(reg_addr(ch, REG_STATUS), q);
         check_value("status", q & 32'hffff_fff9, {31'b0, c[CFG_ENABLE_BIT]});
      end
      repeat (4) begin
         bus_read(ADDR_WIDTH'(16 + int'($unsigned($random(seed)) % 240)), q);
         check_value("unmapped rdata", q, 0);
      end
      for (int ch = 0; ch < NUM_CH; ch++) bus_write(reg_addr(ch, REG_CONFIG), 0);
      test_done("register read-back");

      bus_write(reg_addr(0, REG_PERIOD), 32'h0000_5a5a);
      bus_access(1'b0, reg_addr(0, REG_PERIOD), '0, 12, q);
      check_value("stalled read", q, 32'h0000_5a5a);
      bus_access(1'b1, reg_addr(0, REG_PERIOD), 32'h0000_0007, 9, q);
      check_value("rdata on write", q, 0);
      test_done("handshake");

      for (int ch = 0; ch < NUM_CH; ch++) begin
         per[ch]  = 4 + int'($unsigned($random(seed)) % 17);
         on_t[ch] = 1 + int'($unsigned($random(seed)) % (per[ch] - 1));
         bus_write(reg_addr(ch, REG_PERIOD), 32'(per[ch]));
         bus_write(reg_addr(ch, REG_ON_TIME), 32'(on_t[ch]));
         bus_write(reg_addr(ch, REG_CONFIG), 1);
      end
      for (int ch = 0; ch < NUM_CH; ch++) arm(ch, on_t[ch], per[ch] - on_t[ch]);
      for (int ch = 0; ch < NUM_CH; ch++) wait_runs(ch, 7);
      for (int ch = 0; ch < NUM_CH; ch++) begin
         bus_read(reg_addr(ch, REG_STATUS), q);
         check_value("status enable and running", q & 3, 3);
      end
      for (int ch = 0; ch < NUM_CH; ch++) begin
         check_after[ch] = 1 << 30;
         bus_write(reg_addr(ch, REG_CONFIG), 0);
      end
      test_done("waveform and channel independence");

      bus_write(reg_addr(1, REG_PERIOD), 10);
      bus_write(reg_addr(1, REG_ON_TIME), 0);
      bus_write(reg_addr(1, REG_CONFIG), 1);
      hold_level(1, 1'b0, 30);
      bus_write(reg_addr(1, REG_ON_TIME), 15);
      repeat (12) @(negedge clk);
      hold_level(1, 1'b1, 30);
      // enable, running and a high level
      bus_read(reg_addr(1, REG_STATUS), q);
      check_value("status with output high", q, 32'h7);
      bus_write(reg_addr(1, REG_CONFIG), 0);
      // enable cleared two edges before bus_write returns
      check_value("pwm_out[1] after disable", 32'(pwm_out[1]), 0);
      hold_level(1, 1'b0, 4);
      bus_write(reg_addr(1, REG_PERIOD), 0);
      bus_write(reg_addr(1, REG_CONFIG), 1);
      repeat (3) @(negedge clk);
      bus_read(reg_addr(1, REG_STATUS), q);
      check_value("status running", (q >> STAT_RUNNING_BIT) & 1, 0);
      hold_level(1, 1'b0, 20);
      bus_write(reg_addr(1, REG_CONFIG), 0);
      test_done("edge cases");

      // new on time lands in the middle of a high phase
      bus_write(reg_addr(2, REG_PERIOD), 20);
      bus_write(reg_addr(2, REG_ON_TIME), 8);
      bus_write(reg_addr(2, REG_CONFIG), 1);
      arm(2, 8, 12);
      wait_runs(2, 3);
      wait_level(2, 1'b0);
      wait_level(2, 1'b1);
      bus_write(reg_addr(2, REG_ON_TIME), 12);
      wait_level(2, 1'b0);
      @(posedge clk);
      exp_hi[2] = 12;
      wait_level(2, 1'b1);
      @(posedge clk);
      exp_lo[2] = 8;
      wait_runs(2, 4);
      check_after[2] = 1 << 30;
      bus_write(reg_addr(2, REG_CONFIG), 0);
      test_done("reload at period boundary");

      $display("tests passed %0d, failed %0d, check errors %0d",
               tests_passed, tests_failed, total_errors());
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: simulation ran past %0d cycles", WATCHDOG_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== pwm_subsystem.sv ====
/*
 * PWM subsystem top level
 * host handshake port and a row of identical PWM channels
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_subsystem import pwm_pkg::*; #(
   parameter int NUM_CHANNELS = 4
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    req,
   input  logic                    rw,
   input  logic [ADDR_WIDTH-1:0]   addr,
   input  logic [DATA_WIDTH-1:0]   wdata,
   output logic                    ack,
   output logic [DATA_WIDTH-1:0]   rdata,
   output logic [NUM_CHANNELS-1:0] pwm_out
);

   logic                               wr_strobe, rd_strobe;
   logic [NUM_CHANNELS*DATA_WIDTH-1:0] rd_words;

   bus_handshake_fsm #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) u_bus (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .rw        (rw),
      .rd_words  (rd_words),
      .ack       (ack),
      .wr_strobe (wr_strobe),
      .rd_strobe (rd_strobe),
      .rdata     (rdata)
   );

   // channel n decodes addresses n*4 .. n*4+3
   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
      pwm_channel #(
         .PWM_UNIT (i)
      ) u_channel (
         .clk       (clk),
         .reset     (reset),
         .wr_strobe (wr_strobe),
         .rd_strobe (rd_strobe),
         .addr      (addr),
         .wdata     (wdata),
         .rd_word   (rd_words[i*DATA_WIDTH +: DATA_WIDTH]),
         .pwm_out   (pwm_out[i])
      );
   end

endmodule

`default_nettype wire

// ==== pwm_channel.sv ====
/*
 * one PWM channel
 *   period, on time, config and status registers with block decode
 *   period and on-time down counters, timer controller instance
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_channel import pwm_pkg::*; #(
   parameter int PWM_UNIT = 0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr_strobe,
   input  logic                  rd_strobe,
   input  logic [ADDR_WIDTH-1:0] addr,
   input  logic [DATA_WIDTH-1:0] wdata,
   output logic [DATA_WIDTH-1:0] rd_word,
   output logic                  pwm_out
);

   localparam int BLOCK_WIDTH = ADDR_WIDTH - REG_SEL_WIDTH;
   localparam logic [BLOCK_WIDTH-1:0] BLOCK = BLOCK_WIDTH'(PWM_UNIT);

   logic [DATA_WIDTH-1:0] period_reg, on_time_reg;
   logic                  enable_reg;
   logic [DATA_WIDTH-1:0] period_cnt, on_cnt;
   logic [DATA_WIDTH-1:0] period_load, on_load;
   logic [DATA_WIDTH-1:0] cfg_word, stat_word;
   logic                  hit;
   logic [REG_SEL_WIDTH-1:0] reg_sel;
   logic period_zero, on_zero;
   logic dec_on, dec_period, reload, running, pwm;

   assign hit     = (addr[ADDR_WIDTH-1:REG_SEL_WIDTH] == BLOCK);
   assign reg_sel = addr[REG_SEL_WIDTH-1:0];

   // host writes, status is read only
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_reg  <= '0;
         on_time_reg <= '0;
         enable_reg  <= 1'b0;
      end else if (wr_strobe && hit) begin
         case (reg_sel)
            REG_PERIOD:  period_reg  <= wdata;
            REG_ON_TIME: on_time_reg <= wdata;
            REG_CONFIG:  enable_reg  <= wdata[CFG_ENABLE_BIT];
            default:     ;
         endcase
      end
   end

   // on time is clamped to the period so the output simply stays high
   assign on_load = (on_time_reg > period_reg) ? period_reg : on_time_reg;

   // a reload at a period boundary is also the first counted cycle
   assign period_load = (dec_period && period_reg != '0) ?
                        period_reg - DATA_WIDTH'(1) : period_reg;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_cnt <= '0;
         on_cnt     <= '0;
      end else if (reload) begin
         period_cnt <= period_load;
         on_cnt     <= on_load;
      end else begin
         if (dec_period) period_cnt <= period_cnt - DATA_WIDTH'(1);
         if (dec_on)     on_cnt     <= on_cnt - DATA_WIDTH'(1);
      end
   end

   assign period_zero = (period_cnt == '0);
   assign on_zero     = (on_cnt == '0);

   pwm_timer_fsm u_timer (
      .clk         (clk),
      .reset       (reset),
      .enable      (enable_reg),
      .on_zero     (on_zero),
      .period_zero (period_zero),
      .dec_on      (dec_on),
      .dec_period  (dec_period),
      .reload      (reload),
      .running     (running),
      .pwm         (pwm)
   );

   assign pwm_out = pwm;

   always_comb begin
      cfg_word                   = '0;
      cfg_word[CFG_ENABLE_BIT]   = enable_reg;
      stat_word                  = '0;
      stat_word[STAT_ENABLE_BIT] = enable_reg;
      stat_word[STAT_RUNNING_BIT] = running;
      stat_word[STAT_LEVEL_BIT]  = pwm;
   end

   // zero unless this block is read, so the bus side can OR all channels
   always_comb begin
      rd_word = '0;
      if (rd_strobe && hit) begin
         case (reg_sel)
            REG_PERIOD:  rd_word = period_reg;
            REG_ON_TIME: rd_word = on_time_reg;
            REG_CONFIG:  rd_word = cfg_word;
            REG_STATUS:  rd_word = stat_word;
            default:     rd_word = '0;
         endcase
      end
   end

   // counters step together, on count never runs ahead of the period
   a_on_within_period: assert property (@(posedge clk) disable iff (!reset)
      running |-> ({1'b0, on_cnt} <= {1'b0, period_cnt} + (DATA_WIDTH + 1)'(1)));

endmodule

`default_nettype wire

// ==== pwm_timer_fsm.sv ====
/*
 * PWM timer controller
 * sequences the on and off phases and asks for counter reloads
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_timer_fsm import pwm_pkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic enable,
   input  logic on_zero,
   input  logic period_zero,
   output logic dec_on,
   output logic dec_period,
   output logic reload,
   output logic running,
   output logic pwm
);

   timer_state_t state, next_state;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      dec_on     = 1'b0;
      dec_period = 1'b0;
      reload     = 1'b0;
      case (state)
         // counters track the registers while idle
         IDLE: begin
            reload = 1'b1;
            if (enable && !period_zero) next_state = LOAD;
         end
         // period written to zero at the same edge falls back here
         LOAD: begin
            dec_period = !period_zero;
            if (!enable || period_zero) next_state = IDLE;
            else                        next_state = ON_PHASE;
         end
         ON_PHASE: begin
            dec_period = 1'b1;
            dec_on     = !on_zero;
            if (!enable) begin
               next_state = IDLE;
            end else if (period_zero) begin
               reload     = 1'b1;
               next_state = ON_PHASE;
            end else if (on_zero) begin
               next_state = OFF_PHASE;
            end
         end
         OFF_PHASE: begin
            dec_period = 1'b1;
            if (!enable) begin
               next_state = IDLE;
            end else if (period_zero) begin
               reload     = 1'b1;
               next_state = ON_PHASE;
            end
         end
         default: next_state = IDLE;
      endcase
   end

   assign running = (state != IDLE);

   // high while the on count is still running, dropped at once on disable
   assign pwm = (state == ON_PHASE) && !on_zero && enable;

   a_idle_low: assert property (@(posedge clk) disable iff (!reset)
      (state == IDLE) |-> !pwm);

endmodule

`default_nettype wire

// ==== bus_handshake_fsm.sv ====
/*
 * slave side of the four-phase req/ack host handshake
 * one read or write strobe per request, read data merged over all channels
 */
`timescale 1ns/1ps
`default_nettype none

module bus_handshake_fsm import pwm_pkg::*; #(
   parameter int NUM_CHANNELS = 4
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               req,
   input  logic                               rw,
   input  logic [NUM_CHANNELS*DATA_WIDTH-1:0] rd_words,
   output logic                               ack,
   output logic                               wr_strobe,
   output logic                               rd_strobe,
   output logic [DATA_WIDTH-1:0]              rdata
);

   typedef enum logic [1:0] {
      WAIT_REQ = 2'd0,
      STROBE   = 2'd1,
      ACK_HOLD = 2'd2
   } bus_state_t;

   bus_state_t state, next_state;
   logic [DATA_WIDTH-1:0] rd_merge;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= WAIT_REQ;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         WAIT_REQ: if (req) next_state = STROBE;
         STROBE:   next_state = ACK_HOLD;
         ACK_HOLD: if (!req) next_state = WAIT_REQ;
         default:  next_state = WAIT_REQ;
      endcase
   end

   // strobes last exactly the one STROBE cycle
   assign wr_strobe = (state == STROBE) && rw;
   assign rd_strobe = (state == STROBE) && !rw;
   assign ack       = (state == ACK_HOLD);

   // channels drive zero unless selected by a read
   always_comb begin
      rd_merge = '0;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         rd_merge = rd_merge | rd_words[i*DATA_WIDTH +: DATA_WIDTH];
      end
   end

   // on a write every channel returns zero, so rdata clears too
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         rdata <= '0;
      end else if (state == STROBE) begin
         rdata <= rd_merge;
      end
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (!reset)
      !(wr_strobe && rd_strobe));

   // host holds req until it sees ack
   a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
      $rose(ack) |-> req);

endmodule

`default_nettype wire

// ==== pwm_pkg.sv ====
/*
 * shared definitions for the PWM subsystem
 *   bus and register widths, register offsets within a channel block,
 *   config and status bit positions, timer controller state encoding
 */
`default_nettype none

package pwm_pkg;

   // host bus
   localparam int DATA_WIDTH = 32;
   localparam int ADDR_WIDTH = 8;

   // each channel owns a block of four registers
   localparam int REGS_PER_CHANNEL = 4;
   localparam int REG_SEL_WIDTH    = $clog2(REGS_PER_CHANNEL);

   localparam logic [REG_SEL_WIDTH-1:0] REG_PERIOD  = 2'd0;
   localparam logic [REG_SEL_WIDTH-1:0] REG_ON_TIME = 2'd1;
   localparam logic [REG_SEL_WIDTH-1:0] REG_CONFIG  = 2'd2;
   localparam logic [REG_SEL_WIDTH-1:0] REG_STATUS  = 2'd3;

   // config register, only the enable bit is stored
   localparam int CFG_ENABLE_BIT = 0;

   // status register, read only
   localparam int STAT_ENABLE_BIT  = 0;
   localparam int STAT_RUNNING_BIT = 1;
   localparam int STAT_LEVEL_BIT   = 2;

   typedef enum logic [1:0] {
      IDLE      = 2'd0,
      LOAD      = 2'd1,
      ON_PHASE  = 2'd2,
      OFF_PHASE = 2'd3
   } timer_state_t;

endpackage

`default_nettype wire
